/* Bender.yml */
package:
  name: snac

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/snac_pkg.sv
      - verilog/snac_pad_if.sv
      - verilog/snac_apb_regs.sv
      - verilog/snac_serlatch_ctrl.sv
      - verilog/snac_port_map.sv
      - verilog/snac_top.sv
  - target: test
    files:
      - verif/tb_clkgen.sv
      - verif/snac_checker.sv
      - verif/snac_sva.sv
      - verif/tb_snac.sv

/* filelist.f */
+incdir+verilog
verilog/snac_pkg.sv
verilog/snac_pad_if.sv
verilog/snac_apb_regs.sv
verilog/snac_serlatch_ctrl.sv
verilog/snac_port_map.sv
verilog/snac_top.sv
verif/tb_clkgen.sv
verif/snac_checker.sv
verif/snac_sva.sv
verif/tb_snac.sv

/* verif/snac_checker.sv */
/*
  Compares DUT ports at the falling clock edge, where all of them are settled.
  Expected values and check enables come from the testbench top.
*/
`timescale 1ns/1ns
`default_nettype none

module snac_checker (
    input wire        i_clk,
    input wire        i_psel,
    input wire        i_penable,
    input wire [31:0] i_prdata,
    input wire        i_pready,
    input wire        i_pslverr,
    input wire [15:0] i_p1_btn,
    input wire [15:0] i_p2_btn,
    input wire        i_bk0_dir,
    input wire        i_pin30_dir,
    input wire        i_pin31_dir,
    input wire        i_chk_btn,
    input wire [15:0] i_exp_p1,
    input wire [15:0] i_exp_p2,
    input wire        i_chk_rd,
    input wire [31:0] i_exp_rdata,
    input wire [31:0] i_exp_rmask,
    input wire        i_chk_err,
    input wire        i_exp_slverr,
    input wire        i_chk_dir,
    input wire [31:0] i_sva_errs
);

    int value_errs = 0;
    int other_errs = 0;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        other_errs++;
    endtask

    function automatic int total_errors();
        return value_errs + other_errs + int'(i_sva_errs);
    endfunction

    task automatic print_counts();
        $display("Error counts: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errs, other_errs, i_sva_errs);
    endtask

    always @(negedge i_clk) begin
        if (i_chk_btn) begin
            compare("o_p1_btn", {16'h0, i_p1_btn}, {16'h0, i_exp_p1});
            compare("o_p2_btn", {16'h0, i_p2_btn}, {16'h0, i_exp_p2});
        end
        // APB access cycle, never a wait state
        if (i_psel && i_penable) begin
            compare("o_pready", {31'h0, i_pready}, 32'h1);
        end
        if (i_psel && i_penable && i_chk_rd) begin
            compare("o_prdata", i_prdata & i_exp_rmask, i_exp_rdata & i_exp_rmask);
        end
        if (i_psel && i_penable && i_chk_err) begin
            compare("o_pslverr", {31'h0, i_pslverr}, {31'h0, i_exp_slverr});
        end
        // Configuration-A directions
        if (i_chk_dir) begin
            compare("o_cart_bk0_dir", {31'h0, i_bk0_dir}, 32'h0);
            compare("o_cart_pin30_dir", {31'h0, i_pin30_dir}, 32'h1);
            compare("o_cart_pin31_dir", {31'h0, i_pin31_dir}, 32'h0);
        end
    end

endmodule

`default_nettype wire

/* verif/snac_sva.sv */
/*
  Pad and APB protocol assertions, bound into snac_top.
*/
`timescale 1ns/1ns
`default_nettype none

module snac_sva (
    input wire       i_clk,
    input wire       i_rst_n,
    input wire [1:0] i_bk1_out,
    input wire       i_pready,
    input wire [2:0] i_dirs
);

    // Number of failed assertions so far
    int fail_cnt = 0;

    // Latch only rises with clock parked high
    a_lat_clk: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_bk1_out[1] && !i_bk1_out[0]))
        else begin
            fail_cnt++;
            $error("latch high while pad clock low");
        end

    a_pready: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_pready)
        else begin
            fail_cnt++;
            $error("PREADY dropped");
        end

    a_dirs: assert property (@(posedge i_clk) disable iff (!i_rst_n) $stable(i_dirs))
        else begin
            fail_cnt++;
            $error("pin direction changed");
        end

endmodule

bind snac_top snac_sva u_sva (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_bk1_out (o_cart_bk1_out),
    .i_pready  (o_pready),
    .i_dirs    ({o_cart_bk0_dir, o_cart_pin30_dir, o_cart_pin31_dir})
);

`default_nettype wire

/* verif/snac_tests.txt */
# type(decimal: 0 off, 1 DB15, 2 NES, 3 SNES, 9 DB15_FAST) p1 p2 (hex)
# pattern bit i set means the i-th button after latch is pressed
2 00A5 003C
3 8001 F00F
1 1234 ABCD
9 FFFF 0001
0 0000 0000
2 FF81 7E7E
3 5AA5 0FF0
9 8421 1248

/* verif/tb_clkgen.sv */
/*
  Free-running 40 ns clock, reset released 5 ns after the 10th rising edge.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk   = 1'b0;
        o_rst_n = 1'b0;
        repeat (10) @(posedge o_clk);
        #5 o_rst_n = 1'b1;
    end

    always #20 o_clk = ~o_clk;

endmodule

`default_nettype wire

/* verif/tb_snac.sv */
/*
  Top testbench, runs the lines of verif/snac_tests.txt against two modelled pads.
  Pads advance on the falling pad clock, the engine samples on its rise.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_snac;

    logic        clk;
    logic        rst_n;
    logic        psel = 0, penable = 0, pwrite = 0;
    logic [3:0]  paddr = 0;
    logic [31:0] pwdata = 0;
    wire  [31:0] prdata;
    wire         pready, pslverr, bk0_dir, pin30_out, pin30_dir, pin31_dir;
    wire  [1:0]  bk1_out;
    wire  [15:0] p1_btn, p2_btn;
    // Pad shift registers hold line levels, low is pressed
    logic [15:0] sr1 = '1, sr1_alt = '1, sr2 = '1;
    logic [15:0] pat1 = 0, pat2 = 0, split = '1;
    logic        clk1_q = 1, clk2_q = 1;
    logic        chk_btn = 0, chk_rd = 0, chk_err = 0, exp_slverr = 0, chk_dir = 0;
    logic [15:0] exp_p1 = 0, exp_p2 = 0;
    logic [31:0] exp_rdata = 0, exp_rmask = 0;
    int          cycle = 0;

    tb_clkgen u_clkgen (.o_clk(clk), .o_rst_n(rst_n));

    snac_top dut (
        .i_clk(clk), .i_rst_n(rst_n), .i_psel(psel), .i_penable(penable),
        .i_pwrite(pwrite), .i_paddr(paddr), .i_pwdata(pwdata), .o_prdata(prdata),
        .o_pready(pready), .o_pslverr(pslverr),
        .i_cart_bk0_in({2'b11, sr2[0], sr1[0]}), .i_cart_pin31_in(sr1_alt[0]),
        .o_cart_bk0_dir(bk0_dir), .o_cart_bk1_out(bk1_out), .o_cart_pin30_out(pin30_out),
        .o_cart_pin30_dir(pin30_dir), .o_cart_pin31_dir(pin31_dir),
        .o_p1_btn(p1_btn), .o_p2_btn(p2_btn)
    );

    snac_checker u_chk (
        .i_clk(clk), .i_psel(psel), .i_penable(penable), .i_prdata(prdata),
        .i_pready(pready), .i_pslverr(pslverr), .i_p1_btn(p1_btn), .i_p2_btn(p2_btn),
        .i_bk0_dir(bk0_dir), .i_pin30_dir(pin30_dir), .i_pin31_dir(pin31_dir),
        .i_chk_btn(chk_btn), .i_exp_p1(exp_p1), .i_exp_p2(exp_p2), .i_chk_rd(chk_rd),
        .i_exp_rdata(exp_rdata), .i_exp_rmask(exp_rmask), .i_chk_err(chk_err),
        .i_exp_slverr(exp_slverr), .i_chk_dir(chk_dir), .i_sva_errs(dut.u_sva.fail_cnt)
    );

    always @(posedge clk) cycle++;

    // Pad models, load while latch is high, shift in released past the end
    always @(posedge clk) begin
        #5;
        if (bk1_out[1]) begin
            sr1     <= ~(pat1 & split);
            sr1_alt <= ~(pat1 & ~split);
            sr2     <= ~pat2;
        end else begin
            if (!bk1_out[0] && clk1_q) begin
                sr1     <= {1'b1, sr1[15:1]};
                sr1_alt <= {1'b1, sr1_alt[15:1]};
            end
            if (!pin30_out && clk2_q) sr2 <= {1'b1, sr2[15:1]};
        end
        clk1_q <= bk1_out[0];
        clk2_q <= pin30_out;
    end

    task automatic step_cycle();
        @(posedge clk);
        #5;
    endtask

    // One APB transfer after a random idle gap
    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        repeat ($urandom_range(3, 0)) step_cycle();
        psel   = 1;
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        step_cycle();
        penable = 1;
        #10 rdata = prdata;
        step_cycle();
        psel    = 0;
        penable = 0;
    endtask

    task automatic read_check(input logic [3:0] addr, input logic [31:0] exp,
                              input logic [31:0] mask, input logic err);
        logic [31:0] rd;
        exp_rdata  = exp;
        exp_rmask  = mask;
        exp_slverr = err;
        chk_rd     = (mask != 0);
        chk_err    = 1;
        apb_xfer(0, addr, 0, rd);
        chk_rd  = 0;
        chk_err = 0;
    endtask

    task automatic write_check(input logic [3:0] addr, input logic [31:0] data, input logic err);
        logic [31:0] rd;
        exp_slverr = err;
        chk_err    = 1;
        apb_xfer(1, addr, data, rd);
        chk_err = 0;
    endtask

    task automatic check_buttons(input logic [15:0] e1, input logic [15:0] e2);
        exp_p1  = e1;
        exp_p2  = e2;
        chk_btn = 1;
        step_cycle();
        chk_btn = 0;
        read_check(4'h8, {16'h0, e1}, 32'hFFFF_FFFF, 0);
        read_check(4'hC, {16'h0, e2}, 32'hFFFF_FFFF, 0);
    endtask

    // Poll STATUS until the counter reaches target
    task automatic wait_count(input logic [7:0] target, input int limit);
        logic [31:0] rd;
        int          start;
        start = cycle;
        rd    = 0;
        apb_xfer(0, 4'h4, 0, rd);
        while (rd[15:8] != target) begin
            if (cycle - start > limit) begin
                u_chk.note_failure($sformatf("poll counter never reached %0d", target));
                break;
            end
            apb_xfer(0, 4'h4, 0, rd);
        end
    endtask

    task automatic run_test(input int code, input logic [15:0] p1, input logic [15:0] p2);
        logic [31:0] rd;
        logic [15:0] mask;
        int          start;
        pat1  = p1;
        pat2  = p2;
        split = (code == 1 || code == 9) ? 16'($urandom) : 16'hFFFF;
        mask  = (code == 2) ? 16'h00FF : 16'hFFFF;
        // Pass through DISABLED so every test starts with a type change
        write_check(4'h0, 0, 0);
        repeat (3) step_cycle();
        write_check(4'h0, code, 0);
        repeat (4) step_cycle();
        apb_xfer(0, 4'h4, 0, rd);
        if (code == 1 || code == 2 || code == 3 || code == 9) begin
            // Second poll after the change, so a repeated poll is covered too
            wait_count(rd[15:8] + 8'd2, 40000);
            check_buttons(p1 & mask, p2 & mask);
            read_check(4'h0, code, 32'h1F, 0);
        end else begin
            check_buttons(0, 0);
            start = cycle;
            while (cycle - start < 3000) begin
                read_check(4'h4, {16'h0, rd[15:8], 8'h00}, 32'hFF01, 0);
            end
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          code;
        logic [15:0] p1;
        logic [15:0] p2;
        logic [639:0] line;
        fd = $urandom(21797);
        fd = $fopen("verif/snac_tests.txt", "r");
        if (fd == 0) u_chk.note_failure("cannot open verif/snac_tests.txt");
        n = 0;
        while (rst_n !== 1'b1 && n < 100) begin
            step_cycle();
            n++;
        end
        if (rst_n !== 1'b1) u_chk.note_failure("reset never released");
        // Reset state
        chk_dir = 1;
        step_cycle();
        chk_dir = 0;
        read_check(4'h4, 0, 32'hFFFF_FFFF, 0);
        check_buttons(0, 0);
        // Illegal accesses leave CTRL and STATUS alone
        read_check(4'h2, 0, 0, 1);
        write_check(4'h4, 32'hFFFF, 1);
        write_check(4'h6, 32'h3, 1);
        write_check(4'h8, 32'h2, 1);
        read_check(4'h0, 0, 32'h1F, 0);
        read_check(4'h4, 0, 32'hFFFF, 0);
        while (fd != 0 && !$feof(fd)) begin
            line = 0;
            n    = $fgets(line, fd);
            n    = $sscanf(line, "%d %h %h", code, p1, p2);
            if (n == 3) run_test(code, p1, p2);
        end
        if (fd != 0) $fclose(fd);
        u_chk.print_counts();
        if (u_chk.total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/snac_apb_regs.sv */
/*
  APB slave, no wait states, PSLVERR on unmapped or read-only writes.
  Only CTRL is writable, the other registers are status readback.
  Read data is combinational in the access cycle.
*/
`timescale 1ns/1ns
`default_nettype none

`include "snac_config.svh"

module snac_apb_regs (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire                        i_psel,
    input  wire                        i_penable,
    input  wire                        i_pwrite,
    input  wire [`SNAC_APB_AW-1:0]     i_paddr,
    input  wire [`SNAC_APB_DW-1:0]     i_pwdata,
    output logic [`SNAC_APB_DW-1:0]    o_prdata,
    output logic                       o_pready,
    output logic                       o_pslverr,
    input  wire snac_pkg::btn_word_t   i_p1_btn,
    input  wire snac_pkg::btn_word_t   i_p2_btn,
    input  wire                        i_busy,
    input  wire                        i_poll_done,
    output snac_pkg::ctrl_type_e       o_ctrl_type
);

    snac_pkg::reg_idx_e reg_idx;
    logic               addr_hit;
    logic               access;
    logic               wr_ctrl;
    logic [7:0]         poll_cnt;

    // Address decode, only the four word offsets exist
    always_comb begin
        addr_hit = 1'b1;
        reg_idx  = snac_pkg::REG_CTRL;
        case (i_paddr)
            `SNAC_REG_CTRL:   reg_idx = snac_pkg::REG_CTRL;
            `SNAC_REG_STATUS: reg_idx = snac_pkg::REG_STATUS;
            `SNAC_REG_P1:     reg_idx = snac_pkg::REG_P1;
            `SNAC_REG_P2:     reg_idx = snac_pkg::REG_P2;
            default:          addr_hit = 1'b0;
        endcase
    end

    // Second cycle of a transfer
    assign access  = i_psel & i_penable;
    assign wr_ctrl = access & i_pwrite & addr_hit & (reg_idx == snac_pkg::REG_CTRL);

    // No back-pressure
    assign o_pready  = 1'b1;
    // Bad address, or write to a read-only word
    assign o_pslverr = access & (~addr_hit | (i_pwrite & (reg_idx != snac_pkg::REG_CTRL)));

    // Controller type, any 5-bit code is kept
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ctrl_type <= snac_pkg::CT_DISABLED;
        end else if (wr_ctrl) begin
            o_ctrl_type <= snac_pkg::ctrl_type_e'(i_pwdata[4:0]);
        end
    end

    // Counts finished polls, wraps at 255
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            poll_cnt <= 8'd0;
        end else if (i_poll_done) begin
            poll_cnt <= poll_cnt + 8'd1;
        end
    end

    // Readback mux
    always_comb begin
        o_prdata = '0;
        if (addr_hit) begin
            case (reg_idx)
                snac_pkg::REG_CTRL:   o_prdata[4:0]  = o_ctrl_type;
                snac_pkg::REG_STATUS: begin
                    o_prdata[0]    = i_busy;
                    o_prdata[15:8] = poll_cnt;
                end
                snac_pkg::REG_P1:     o_prdata[15:0] = i_p1_btn;
                default:              o_prdata[15:0] = i_p2_btn;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/snac_config.svh */
/*
  Build constants for the cartridge controller adapter.
  Polling rates assume SNAC_CLK_HZ is the real i_clk rate.
  Register offsets are byte addresses on a word-aligned APB bus.
*/
`ifndef SNAC_CONFIG_SVH
`define SNAC_CONFIG_SVH

// System clock
`define SNAC_CLK_HZ            25_000_000

// Poll rates, the strobe runs at twice these
`define SNAC_NES_POLL_HZ       50_000
`define SNAC_DB15_POLL_HZ      200_000
`define SNAC_DB15_FAST_POLL_HZ 400_000
`define SNAC_ACC_W             32

// Bits per poll, DB15 reads as many as SNES
`define SNAC_NES_BITS          8
`define SNAC_SNES_BITS         16

// APB bus and register map
`define SNAC_APB_AW            4
`define SNAC_APB_DW            32
`define SNAC_REG_CTRL          4'h0
`define SNAC_REG_STATUS        4'h4
`define SNAC_REG_P1            4'h8
`define SNAC_REG_P2            4'hC

`endif

/* verilog/snac_pad_if.sv */
/*
  Controller-side pad lines between engine and pin routing.
  dat1_alt is the crossed-cable copy of data 1, only DB15 uses it.
*/
`timescale 1ns/1ns
`default_nettype none

interface snac_pad_if;

    // Shared by both controllers
    logic pad_lat;
    logic pad_clk;

    // Serial data, active low from the pads
    logic dat1;
    logic dat1_alt;
    logic dat2;

    modport ctrl (output pad_lat, output pad_clk, input dat1, input dat1_alt, input dat2);

    modport pad (input pad_lat, input pad_clk, output dat1, output dat1_alt, output dat2);

endinterface

`default_nettype wire

/* verilog/snac_pkg.sv */
/*
  Types for controller polling.
  Unlisted controller codes are stored as written and act as DISABLED.
*/
`default_nettype none

package snac_pkg;

    // Controller code as written into CTRL[4:0]
    typedef enum logic [4:0] {
        CT_DISABLED  = 5'd0,
        CT_DB15      = 5'd1,
        CT_NES       = 5'd2,
        CT_SNES      = 5'd3,
        CT_DB15_FAST = 5'd9
    } ctrl_type_e;

    // Pressed buttons, bit i is the i-th bit after latch, high when pressed
    typedef logic [15:0] btn_word_t;

    // Engine phase, named after what the pad lines are doing
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_LATCH,
        PH_CLK_LOW,
        PH_CLK_HIGH,
        PH_DONE
    } poll_phase_e;

    // Word index of the APB registers
    typedef enum logic [1:0] {
        REG_CTRL,
        REG_STATUS,
        REG_P1,
        REG_P2
    } reg_idx_e;

endpackage

`default_nettype wire

/* verilog/snac_port_map.sv */
/*
  Configuration-A pin routing only, pin directions never change.
  Inputs cross through two flops, outputs add one cycle of delay.
  Bank-0 bits 7:6 are not routed in this configuration.
*/
`timescale 1ns/1ns
`default_nettype none

module snac_port_map (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire [3:0]  i_cart_bk0_in,
    input  wire        i_cart_pin31_in,
    output logic       o_cart_bk0_dir,
    output logic [1:0] o_cart_bk1_out,
    output logic       o_cart_pin30_out,
    output logic       o_cart_pin30_dir,
    output logic       o_cart_pin31_dir,
    snac_pad_if.pad    pad
);

    // Sync stages, index 1 is the output
    logic [1:0] dat1_sync;
    logic [1:0] dat1_alt_sync;
    logic [1:0] dat2_sync;

    // bk0 bit 4 is i_cart_bk0_in[0], bit 5 is [1]
    always_ff @(posedge i_clk) begin
        dat1_sync     <= {dat1_sync[0], i_cart_bk0_in[0]};
        dat2_sync     <= {dat2_sync[0], i_cart_bk0_in[1]};
        dat1_alt_sync <= {dat1_alt_sync[0], i_cart_pin31_in};
    end

    assign pad.dat1     = dat1_sync[1];
    assign pad.dat1_alt = dat1_alt_sync[1];
    assign pad.dat2     = dat2_sync[1];

    // Bank-1 bit 7 is latch, bit 6 clock; pin 30 clocks player 2
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cart_bk1_out   <= 2'b01;
            o_cart_pin30_out <= 1'b1;
            o_cart_bk0_dir   <= 1'b0;
            o_cart_pin30_dir <= 1'b1;
            o_cart_pin31_dir <= 1'b0;
        end else begin
            o_cart_bk1_out   <= {pad.pad_lat, pad.pad_clk};
            o_cart_pin30_out <= pad.pad_clk;
            o_cart_bk0_dir   <= 1'b0;
            o_cart_pin30_dir <= 1'b1;
            o_cart_pin31_dir <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/snac_serlatch_ctrl.sv */
/*
  Serial-latch poller for two NES, SNES or DB15 pads on shared latch and clock.
  Pacing comes from a phase accumulator, strobes are ~2x the poll rate.
  A change of controller type restarts everything the next cycle.
*/
`timescale 1ns/1ns
`default_nettype none

`include "snac_config.svh"

module snac_serlatch_ctrl (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire snac_pkg::ctrl_type_e  i_ctrl_type,
    snac_pad_if.ctrl                   pad,
    output snac_pkg::btn_word_t        o_p1_btn,
    output snac_pkg::btn_word_t        o_p2_btn,
    output logic                       o_busy,
    output logic                       o_poll_done
);

    localparam int AW = `SNAC_ACC_W;

    // Step = 2^AW * 2 * rate / clk
    function automatic logic [AW-1:0] calc_step(input logic [63:0] poll_hz);
        logic [63:0] full;
        full = ((64'd1 << AW) * 64'd2 * poll_hz) / 64'(`SNAC_CLK_HZ);
        return full[AW-1:0];
    endfunction

    localparam logic [AW-1:0] STEP_NES       = calc_step(`SNAC_NES_POLL_HZ);
    localparam logic [AW-1:0] STEP_DB15      = calc_step(`SNAC_DB15_POLL_HZ);
    localparam logic [AW-1:0] STEP_DB15_FAST = calc_step(`SNAC_DB15_FAST_POLL_HZ);

    snac_pkg::ctrl_type_e  type_q;
    logic                  type_chg;
    logic [AW-1:0]         step;
    logic [4:0]            nbits;
    logic                  is_db15;
    logic [AW-1:0]         acc;
    logic [AW:0]           acc_sum;
    logic                  stb;
    snac_pkg::poll_phase_e phase;
    logic [4:0]            bit_idx;
    logic                  last_bit;
    logic                  d1;
    snac_pkg::btn_word_t   sh1;
    snac_pkg::btn_word_t   sh2;

    // Change of type seen against last cycle's copy
    assign type_chg = (type_q != i_ctrl_type);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            type_q <= snac_pkg::CT_DISABLED;
        end else begin
            type_q <= i_ctrl_type;
        end
    end

    // Per-type pacing and length, unknown codes get no strobes
    always_comb begin
        step    = '0;
        nbits   = 5'(`SNAC_NES_BITS);
        is_db15 = 1'b0;
        case (type_q)
            snac_pkg::CT_NES:  step = STEP_NES;
            snac_pkg::CT_SNES: begin
                step  = STEP_NES;
                nbits = 5'(`SNAC_SNES_BITS);
            end
            snac_pkg::CT_DB15: begin
                step    = STEP_DB15;
                nbits   = 5'(`SNAC_SNES_BITS);
                is_db15 = 1'b1;
            end
            snac_pkg::CT_DB15_FAST: begin
                step    = STEP_DB15_FAST;
                nbits   = 5'(`SNAC_SNES_BITS);
                is_db15 = 1'b1;
            end
            default: step = '0;
        endcase
    end

    // Fractional strobe, one cycle high on each carry out
    assign acc_sum = {1'b0, acc} + {1'b0, step};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc <= '0;
            stb <= 1'b0;
        end else if (type_chg) begin
            acc <= '0;
            stb <= 1'b0;
        end else begin
            acc <= acc_sum[AW-1:0];
            stb <= acc_sum[AW];
        end
    end

    // DB15 pulls data 1 low on either pin
    assign d1       = is_db15 ? (pad.dat1 & pad.dat1_alt) : pad.dat1;
    assign last_bit = (bit_idx == nbits - 5'd1);

    // Poll FSM
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase       <= snac_pkg::PH_IDLE;
            pad.pad_lat <= 1'b0;
            pad.pad_clk <= 1'b1;
            o_busy      <= 1'b0;
            o_poll_done <= 1'b0;
            bit_idx     <= 5'd0;
            o_p1_btn    <= '0;
            o_p2_btn    <= '0;
        end else if (type_chg) begin
            phase       <= snac_pkg::PH_IDLE;
            pad.pad_lat <= 1'b0;
            pad.pad_clk <= 1'b1;
            o_busy      <= 1'b0;
            o_poll_done <= 1'b0;
            bit_idx     <= 5'd0;
            o_p1_btn    <= '0;
            o_p2_btn    <= '0;
        end else begin
            o_poll_done <= 1'b0;
            case (phase)
                snac_pkg::PH_IDLE: if (stb) begin
                    pad.pad_lat <= 1'b1;
                    o_busy      <= 1'b1;
                    bit_idx     <= 5'd0;
                    phase       <= snac_pkg::PH_LATCH;
                end
                // Latch falls, bit 0 is already on the line
                snac_pkg::PH_LATCH: if (stb) begin
                    pad.pad_lat <= 1'b0;
                    bit_idx     <= 5'd1;
                    phase       <= snac_pkg::PH_CLK_HIGH;
                end
                snac_pkg::PH_CLK_HIGH: if (stb) begin
                    pad.pad_clk <= 1'b0;
                    phase       <= snac_pkg::PH_CLK_LOW;
                end
                // Rising clock takes the next bit
                snac_pkg::PH_CLK_LOW: if (stb) begin
                    pad.pad_clk <= 1'b1;
                    bit_idx     <= bit_idx + 5'd1;
                    phase       <= last_bit ? snac_pkg::PH_DONE : snac_pkg::PH_CLK_HIGH;
                end
                // Unread bits stay one in the shifters, so they invert to zero
                snac_pkg::PH_DONE: begin
                    o_p1_btn    <= ~sh1;
                    o_p2_btn    <= ~sh2;
                    o_poll_done <= 1'b1;
                    o_busy      <= 1'b0;
                    phase       <= snac_pkg::PH_IDLE;
                end
                default: phase <= snac_pkg::PH_IDLE;
            endcase
        end
    end

    // Sample shifters, preset to released at poll start
    always_ff @(posedge i_clk) begin
        if (phase == snac_pkg::PH_IDLE) begin
            sh1 <= '1;
            sh2 <= '1;
        end else if (stb && (phase == snac_pkg::PH_LATCH || phase == snac_pkg::PH_CLK_LOW)) begin
            sh1[bit_idx[3:0]] <= d1;
            sh2[bit_idx[3:0]] <= pad.dat2;
        end
    end

endmodule

`default_nettype wire

/* verilog/snac_top.sv */
/*
  Cartridge-port controller adapter, configuration A pins only.
  APB never stalls; poll progress shows in the STATUS counter.
*/
`timescale 1ns/1ns
`default_nettype none

`include "snac_config.svh"

module snac_top (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    // APB slave
    input  wire                       i_psel,
    input  wire                       i_penable,
    input  wire                       i_pwrite,
    input  wire [`SNAC_APB_AW-1:0]    i_paddr,
    input  wire [`SNAC_APB_DW-1:0]    i_pwdata,
    output wire [`SNAC_APB_DW-1:0]    o_prdata,
    output wire                       o_pready,
    output wire                       o_pslverr,
    // Cartridge port
    input  wire [3:0]                 i_cart_bk0_in,
    input  wire                       i_cart_pin31_in,
    output wire                       o_cart_bk0_dir,
    output wire [1:0]                 o_cart_bk1_out,
    output wire                       o_cart_pin30_out,
    output wire                       o_cart_pin30_dir,
    output wire                       o_cart_pin31_dir,
    // Latest button words
    output wire snac_pkg::btn_word_t  o_p1_btn,
    output wire snac_pkg::btn_word_t  o_p2_btn
);

    snac_pkg::ctrl_type_e ctrl_type;
    logic                 busy;
    logic                 poll_done;

    snac_pad_if u_pad_if ();

    snac_apb_regs u_regs (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_pwrite    (i_pwrite),
        .i_paddr     (i_paddr),
        .i_pwdata    (i_pwdata),
        .o_prdata    (o_prdata),
        .o_pready    (o_pready),
        .o_pslverr   (o_pslverr),
        .i_p1_btn    (o_p1_btn),
        .i_p2_btn    (o_p2_btn),
        .i_busy      (busy),
        .i_poll_done (poll_done),
        .o_ctrl_type (ctrl_type)
    );

    snac_serlatch_ctrl u_engine (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_ctrl_type (ctrl_type),
        .pad         (u_pad_if),
        .o_p1_btn    (o_p1_btn),
        .o_p2_btn    (o_p2_btn),
        .o_busy      (busy),
        .o_poll_done (poll_done)
    );

    snac_port_map u_port_map (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_cart_bk0_in    (i_cart_bk0_in),
        .i_cart_pin31_in  (i_cart_pin31_in),
        .o_cart_bk0_dir   (o_cart_bk0_dir),
        .o_cart_bk1_out   (o_cart_bk1_out),
        .o_cart_pin30_out (o_cart_pin30_out),
        .o_cart_pin30_dir (o_cart_pin30_dir),
        .o_cart_pin31_dir (o_cart_pin31_dir),
        .pad              (u_pad_if)
    );

endmodule

`default_nettype wire
